// ==== sim.f ====
hdl/dcache_geom_pkg.sv
hdl/dcache_ctrl_pkg.sv
hdl/dcache_ctrl.sv
hdl/dcache_way.sv
hdl/dcache_way_select.sv
hdl/dcache_top.sv
tests/tb_clock_gen.sv
tests/dcache_sva.sv
tests/tb_dcache.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_dcache
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -Fxq "Testbench passed"

clean:
	rm -rf $(BUILD_DIR)

// ==== tests/tb_dcache.sv ====
`default_nettype none

module tb_dcache;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD  = 100;
  localparam int MEM_WORDS   = 1024;  // tags 0..15 fit, byte address bits 11:2
  localparam int LINE_BYTES  = dcache_geom_pkg::WORDS_PER_LINE * 4;
  localparam int N_STALL_OPS = 40;
  localparam int N_RAND_OPS  = 200;
  localparam int TOTAL_OPS   = 2 + 5 + 14 + N_STALL_OPS + N_RAND_OPS + 4 * 10 * 8;
  localparam int MISS_BOUND  = 120;   // cycles for write-back plus refill under stalls
  localparam dcache_geom_pkg::addr_t SET_MASK =
    dcache_geom_pkg::addr_t'(LINE_BYTES * dcache_geom_pkg::NUM_SETS - 1);  // index and offset

  logic clk;
  logic rst;
  logic req_valid;
  logic req_write;
  dcache_geom_pkg::addr_t req_addr;
  dcache_geom_pkg::word_t req_wdata;
  dcache_geom_pkg::strb_t req_wstrb;
  logic req_ready;
  logic rsp_valid;
  dcache_geom_pkg::word_t rsp_data;
  logic rsp_ready;
  logic rd_req_valid;
  dcache_geom_pkg::addr_t rd_req_addr;
  logic rd_req_ready;
  logic rd_rsp_valid;
  dcache_geom_pkg::word_t rd_rsp_data;
  logic rd_rsp_last;
  logic rd_rsp_ready;
  logic wr_req_valid;
  dcache_geom_pkg::addr_t wr_req_addr;
  logic wr_req_ready;
  logic wr_data_valid;
  dcache_geom_pkg::word_t wr_data;
  logic wr_data_last;
  logic wr_data_ready;

  dcache_geom_pkg::word_t mem    [MEM_WORDS];  // backing store
  dcache_geom_pkg::word_t shadow [MEM_WORDS];  // every cpu write lands here at once
  bit                     written[MEM_WORDS];
  dcache_geom_pkg::word_t exp_q  [$];          // expected read data, in order
  logic [31:0] mem_rng;
  logic [31:0] cpu_rng;
  bit stall_en;
  int err_count;
  int check_count;
  int test_base;
  int rd_bursts;
  int wb_bursts;

  tb_clock_gen #(.PERIOD_NS(CLK_PERIOD)) u_clk (.clk(clk));

  dcache_top DUT (.*);

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] mem_rand();
    mem_rng = xorshift(mem_rng);
    return mem_rng;
  endfunction

  function automatic logic [31:0] cpu_rand();
    cpu_rng = xorshift(cpu_rng);
    return cpu_rng;
  endfunction

  // one draw in four stalls when stalls are on
  function automatic bit mem_stall();
    logic [31:0] r;
    r = mem_rand();
    return stall_en && (r[1:0] == 2'b00);
  endfunction

  function automatic bit cpu_stall();
    logic [31:0] r;
    r = cpu_rand();
    return stall_en && (r[1:0] == 2'b00);
  endfunction

  function automatic int word_idx(input dcache_geom_pkg::addr_t a);
    return int'(a[11:2]);
  endfunction

  function automatic dcache_geom_pkg::addr_t line_base(input dcache_geom_pkg::addr_t a);
    return a & ~dcache_geom_pkg::addr_t'(LINE_BYTES - 1);
  endfunction

  function automatic dcache_geom_pkg::word_t fill_word(input dcache_geom_pkg::addr_t a);
    return (a * 32'h9E37_79B1) ^ 32'h5A5A_A5A5;  // scrambles every address bit
  endfunction

  function automatic dcache_geom_pkg::addr_t make_addr(input int tag, input int set,
                                                       input int word);
    dcache_geom_pkg::addr_t a;
    a = '0;
    a[dcache_geom_pkg::ADDR_W-1 -: dcache_geom_pkg::TAG_W] = dcache_geom_pkg::tag_t'(tag);
    a[dcache_geom_pkg::OFFSET_W +: dcache_geom_pkg::INDEX_W] = dcache_geom_pkg::index_t'(set);
    a[dcache_geom_pkg::BYTE_W +: dcache_geom_pkg::WSEL_W] = dcache_geom_pkg::word_sel_t'(word);
    return a;
  endfunction

  // flat memory view: what a read of this address must return
  function automatic dcache_geom_pkg::word_t ref_read(input dcache_geom_pkg::addr_t a);
    return shadow[word_idx(a)];
  endfunction

  task automatic apply_write(input dcache_geom_pkg::addr_t a, input dcache_geom_pkg::word_t d,
                             input dcache_geom_pkg::strb_t s);
    int i;
    i = word_idx(a);
    for (int b = 0; b < dcache_geom_pkg::STRB_W; b++) begin
      if (s[b]) shadow[i][b*8 +: 8] = d[b*8 +: 8];
    end
  endtask

  task automatic report_error(input string what);
    err_count++;
    $display("error at %0t: %s", $time, what);
  endtask

  task automatic check_word(input string name, input dcache_geom_pkg::word_t got,
                            input dcache_geom_pkg::word_t exp);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("mismatch %s: got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_addr(input string name, input dcache_geom_pkg::addr_t got,
                            input dcache_geom_pkg::addr_t exp);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("mismatch %s: got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("mismatch %s: got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic end_test(input string name);
    if (err_count == test_base) $display("test %s: ok", name);
    else $display("test %s: %0d errors", name, err_count - test_base);
    test_base = err_count;
  endtask

  // entered at a negedge, leaves 1 ns after the accepting edge
  task automatic serve_read();
    dcache_geom_pkg::addr_t a;
    int base;
    a = rd_req_addr;
    base = word_idx(a);
    check_addr("rd_req_addr", a, line_base(req_addr));  // line of the pending request
    if (a[31:12] != '0) report_error("refill address outside the modelled memory");
    while (mem_stall()) @(posedge clk);
    @(posedge clk);
    #1 rd_req_ready = 1'b1;
    @(posedge clk);
    #1 rd_req_ready = 1'b0;
    for (int i = 0; i < dcache_geom_pkg::WORDS_PER_LINE; i++) begin
      while (mem_stall()) begin
        rd_rsp_valid = 1'b0;  // gap between beats
        @(posedge clk);
        #1;
      end
      rd_rsp_valid = 1'b1;
      rd_rsp_data  = mem[base + i];
      rd_rsp_last  = (i == dcache_geom_pkg::WORDS_PER_LINE - 1);
      @(negedge clk);
      if (!rd_rsp_ready) report_error("rd_rsp_ready low while a refill beat is offered");
      @(posedge clk);
      #1;
    end
    rd_rsp_valid = 1'b0;
    rd_rsp_last  = 1'b0;
    rd_bursts++;
  endtask

  task automatic serve_write();
    dcache_geom_pkg::addr_t a;
    int base;
    int n;
    a = wr_req_addr;
    base = word_idx(a);
    n = 0;
    // victim sits in the set of the pending request, line aligned
    check_addr("wr_req_addr", a & SET_MASK, line_base(req_addr) & SET_MASK);
    if (a[dcache_geom_pkg::ADDR_W-1 -: dcache_geom_pkg::TAG_W] ==
        req_addr[dcache_geom_pkg::ADDR_W-1 -: dcache_geom_pkg::TAG_W]) begin
      report_error("write-back of the line that is being requested");
    end
    if (a[31:12] != '0) report_error("write-back address outside the modelled memory");
    while (mem_stall()) @(posedge clk);
    @(posedge clk);
    #1 wr_req_ready = 1'b1;
    @(posedge clk);
    #1 wr_req_ready = 1'b0;
    while (n < dcache_geom_pkg::WORDS_PER_LINE) begin
      wr_data_ready = !mem_stall();
      @(negedge clk);
      if (!wr_data_valid) begin
        report_error("wr_data_valid low inside a write-back burst");
      end else if (wr_data_ready) begin
        // dirty data must equal the latest cpu writes
        check_word("wr_data", wr_data, ref_read(a + dcache_geom_pkg::addr_t'(4 * n)));
        check_flag("wr_data_last", wr_data_last, n == dcache_geom_pkg::WORDS_PER_LINE - 1);
        mem[base + n] = wr_data;
        n++;
      end
      @(posedge clk);
      #1;
    end
    wr_data_ready = 1'b0;
    @(negedge clk);
    if (wr_data_valid) report_error("write-back burst longer than eight beats");
    wb_bursts++;
  endtask

  initial begin : memory_model
    mem_rng       = 32'd99;
    rd_req_ready  = 1'b0;
    rd_rsp_valid  = 1'b0;
    rd_rsp_data   = '0;
    rd_rsp_last   = 1'b0;
    wr_req_ready  = 1'b0;
    wr_data_ready = 1'b0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i]    = fill_word(dcache_geom_pkg::addr_t'(i * 4));
      shadow[i] = mem[i];
    end
    forever begin
      @(negedge clk);
      if (!rst) begin
        if (rd_req_valid) serve_read();
        else if (wr_req_valid) serve_write();
      end
    end
  end

  // checks every read response at the sample point before its handshake edge
  initial begin : compare
    forever begin
      @(negedge clk);
      if (rsp_valid && rsp_ready) begin
        if (exp_q.size() == 0) report_error("read response with no read outstanding");
        else check_word("rsp_data", rsp_data, exp_q.pop_front());
      end
    end
  end

  task automatic cpu_op(input bit write, input dcache_geom_pkg::addr_t a,
                        input dcache_geom_pkg::word_t d, input dcache_geom_pkg::strb_t s);
    logic got;
    got = 1'b0;
    req_valid = 1'b1;
    req_write = write;
    req_addr  = a;
    req_wdata = d;
    req_wstrb = s;
    if (write) begin
      apply_write(a, d, s);
      written[word_idx(a)] = 1'b1;
    end else begin
      exp_q.push_back(ref_read(a));
    end
    do @(negedge clk); while (!req_ready);  // miss latency varies
    @(posedge clk);
    #1 req_valid = 1'b0;
    while (!write && !got) begin
      rsp_ready = !cpu_stall();
      @(negedge clk);
      got = rsp_valid && rsp_ready;
      @(posedge clk);
      #1;
    end
    rsp_ready = 1'b0;
  endtask

  initial begin : stimulus
    int n0;
    logic [31:0] r;
    dcache_geom_pkg::strb_t s;
    cpu_rng   = 32'd99;
    stall_en  = 1'b0;
    rst       = 1'b1;
    req_valid = 1'b0;
    req_write = 1'b0;
    req_addr  = '0;
    req_wdata = '0;
    req_wstrb = '0;
    rsp_ready = 1'b0;
    repeat (2) @(posedge clk);
    #1 rst = 1'b0;
    @(negedge clk);
    check_flag("req_ready", req_ready, 1'b0);
    check_flag("rsp_valid", rsp_valid, 1'b0);
    check_flag("rd_req_valid", rd_req_valid, 1'b0);
    check_flag("rd_rsp_ready", rd_rsp_ready, 1'b0);
    check_flag("wr_req_valid", wr_req_valid, 1'b0);
    check_flag("wr_data_valid", wr_data_valid, 1'b0);
    @(posedge clk);
    #1;

    // cold read miss, then a hit in the same line
    n0 = rd_bursts;
    cpu_op(1'b0, make_addr(3, 2, 5), '0, '0);
    cpu_op(1'b0, make_addr(3, 2, 0), '0, '0);
    if (rd_bursts != n0 + 1) report_error("two reads of one line did not cause one refill");
    end_test("cold_read");

    // partial strobes merge into the cached word
    cpu_op(1'b0, make_addr(4, 6, 2), '0, '0);
    cpu_op(1'b1, make_addr(4, 6, 2), 32'hDEAD_BEEF, 4'b0101);
    cpu_op(1'b1, make_addr(4, 6, 3), 32'h1234_5678, 4'b1000);
    cpu_op(1'b0, make_addr(4, 6, 2), '0, '0);
    cpu_op(1'b0, make_addr(4, 6, 3), '0, '0);
    end_test("write_hit_merge");

    // seven dirty tags in set 5 overflow six ways
    n0 = wb_bursts;
    for (int t = 1; t <= 7; t++) cpu_op(1'b1, make_addr(t, 5, t), cpu_rand(), 4'hf);
    for (int t = 1; t <= 7; t++) cpu_op(1'b0, make_addr(t, 5, t), '0, '0);
    if (wb_bursts == n0) report_error("no write-back burst after overfilling a set");
    end_test("eviction");

    stall_en = 1'b1;
    for (int i = 0; i < N_STALL_OPS; i++) begin
      r = cpu_rand();
      cpu_op(r[11:10] == 2'b00, make_addr(int'(r[3:0]), int'(r[6:4]), int'(r[9:7])),
             cpu_rand(), 4'hf);
    end
    end_test("stalls");

    // odd sets only, tags 0..9
    for (int i = 0; i < N_RAND_OPS; i++) begin
      r = cpu_rand();
      s = r[9:6];
      if (s == '0) s = 4'hf;
      cpu_op(r[5], make_addr(int'(r[31:16]) % 10, int'({r[1:0], 1'b1}), int'(r[4:2])),
             cpu_rand(), s);
    end
    for (int t = 0; t < 10; t++) begin
      for (int set = 1; set < 8; set += 2) begin
        for (int w = 0; w < dcache_geom_pkg::WORDS_PER_LINE; w++) begin
          if (written[word_idx(make_addr(t, set, w))]) cpu_op(1'b0, make_addr(t, set, w), '0, '0);
        end
      end
    end
    end_test("random_mix");

    $display("checks %0d, errors %0d", check_count, err_count);
    if (err_count == 0) $display("Testbench passed");
    else $display("Testbench failed");
    $finish;
  end

  initial begin : watchdog
    #(TOTAL_OPS * MISS_BOUND * CLK_PERIOD);
    $display("timeout: operations did not complete within the allowed time");
    $display("Testbench failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tests/dcache_sva.sv ====
`default_nettype none

module dcache_sva (
  input logic                       clk,
  input logic                       rst,
  input dcache_ctrl_pkg::beat_cnt_t beat_cnt,
  input logic                       req_ready,
  input logic                       rsp_valid,
  input logic                       rsp_ready,
  input logic                       rd_req_valid,
  input logic                       rd_req_ready,
  input logic                       wr_req_valid,
  input logic                       wr_req_ready,
  input logic                       wr_data_valid,
  input logic                       wr_data_ready,
  input logic                       wr_data_last
);
  timeunit 1ns;
  timeprecision 1ps;

  // address phases and the read response stay up until taken
  rd_req_hold: assert property (@(posedge clk) disable iff (rst)
    rd_req_valid && !rd_req_ready |=> rd_req_valid)
    else $error("rd_req_valid dropped before rd_req_ready");

  wr_req_hold: assert property (@(posedge clk) disable iff (rst)
    wr_req_valid && !wr_req_ready |=> wr_req_valid)
    else $error("wr_req_valid dropped before wr_req_ready");

  rsp_hold: assert property (@(posedge clk) disable iff (rst)
    rsp_valid && !rsp_ready |=> rsp_valid)
    else $error("rsp_valid dropped before rsp_ready");

  // last only inside a live write-back beat
  last_with_valid: assert property (@(posedge clk) disable iff (rst)
    wr_data_last |-> wr_data_valid)
    else $error("wr_data_last without wr_data_valid");

  // burst is over once the last beat is taken
  last_ends_burst: assert property (@(posedge clk) disable iff (rst)
    wr_data_last && wr_data_ready |=> !wr_data_valid)
    else $error("write-back beats continue after the last beat");

  beat_in_range: assert property (@(posedge clk) disable iff (rst)
    wr_data_valid |-> beat_cnt < dcache_ctrl_pkg::BURST_BEATS)
    else $error("write-back beat counter past burst length");

  accept_vs_respond: assert property (@(posedge clk) disable iff (rst)
    !(req_ready && rsp_valid))
    else $error("req_ready and rsp_valid high together");

endmodule

bind dcache_ctrl dcache_sva u_sva (
  .clk(clk), .rst(rst), .beat_cnt(beat_cnt),
  .req_ready(req_ready), .rsp_valid(rsp_valid), .rsp_ready(rsp_ready),
  .rd_req_valid(rd_req_valid), .rd_req_ready(rd_req_ready),
  .wr_req_valid(wr_req_valid), .wr_req_ready(wr_req_ready),
  .wr_data_valid(wr_data_valid), .wr_data_ready(wr_data_ready),
  .wr_data_last(wr_data_last)
);

`default_nettype wire

// ==== tests/tb_clock_gen.sv ====
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD_NS = 100   // full clock period
) (
  output logic clk
);
  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;  // 50% duty
  end

endmodule

`default_nettype wire

// ==== hdl/dcache_top.sv ====
`default_nettype none

module dcache_top (
  input  logic                   clk,
  input  logic                   rst,
  // cpu port
  input  logic                   req_valid,
  input  logic                   req_write,
  input  dcache_geom_pkg::addr_t req_addr,
  input  dcache_geom_pkg::word_t req_wdata,
  input  dcache_geom_pkg::strb_t req_wstrb,
  output logic                   req_ready,
  output logic                   rsp_valid,
  output dcache_geom_pkg::word_t rsp_data,
  input  logic                   rsp_ready,
  // memory read port, 8-beat bursts
  output logic                   rd_req_valid,
  output dcache_geom_pkg::addr_t rd_req_addr,
  input  logic                   rd_req_ready,
  input  logic                   rd_rsp_valid,
  input  dcache_geom_pkg::word_t rd_rsp_data,
  input  logic                   rd_rsp_last,
  output logic                   rd_rsp_ready,
  // memory write port, 8-beat bursts, all bytes
  output logic                   wr_req_valid,
  output dcache_geom_pkg::addr_t wr_req_addr,
  input  logic                   wr_req_ready,
  output logic                   wr_data_valid,
  output dcache_geom_pkg::word_t wr_data,
  output logic                   wr_data_last,
  input  logic                   wr_data_ready
);

  // controller to ways
  dcache_geom_pkg::index_t    index;
  dcache_geom_pkg::tag_t      tag;
  dcache_geom_pkg::word_sel_t word_sel;
  dcache_geom_pkg::word_t     store_wdata;
  dcache_geom_pkg::strb_t     store_wstrb;
  logic                       store_en;
  logic                       fill_en;
  dcache_geom_pkg::word_t     fill_data;
  logic                       miss_start;

  // ways to selector
  dcache_geom_pkg::way_vec_t  hits;
  dcache_geom_pkg::way_vec_t  valids;
  dcache_geom_pkg::way_vec_t  dirtys;
  dcache_geom_pkg::tag_t      tags  [dcache_geom_pkg::NUM_WAYS];
  dcache_geom_pkg::line_t     lines [dcache_geom_pkg::NUM_WAYS];

  // selector back to controller and ways
  logic                       any_hit;
  dcache_geom_pkg::word_t     read_word;
  dcache_geom_pkg::way_vec_t  victim_onehot;
  logic                       victim_dirty;
  dcache_geom_pkg::tag_t      victim_tag;
  dcache_geom_pkg::line_t     victim_line;

  dcache_ctrl u_ctrl (.*);

  for (genvar w = 0; w < dcache_geom_pkg::NUM_WAYS; w++) begin : g_way
    dcache_way u_way (
      .clk, .rst, .index, .tag, .word_sel, .store_wdata, .store_wstrb,
      .store_en, .fill_en, .fill_data,
      .victim_sel (victim_onehot[w]),
      .hit        (hits[w]),
      .valid      (valids[w]),
      .dirty      (dirtys[w]),
      .tag_out    (tags[w]),
      .line       (lines[w])
    );
  end

  dcache_way_select u_sel (
    .clk, .rst, .hits, .valids, .dirtys, .tags, .lines, .word_sel, .miss_start,
    .any_hit, .read_word, .victim_onehot, .victim_dirty, .victim_tag, .victim_line
  );

endmodule

`default_nettype wire

// ==== hdl/dcache_way_select.sv ====
`default_nettype none

module dcache_way_select (
  input  logic                       clk,
  input  logic                       rst,
  input  dcache_geom_pkg::way_vec_t  hits,
  input  dcache_geom_pkg::way_vec_t  valids,
  input  dcache_geom_pkg::way_vec_t  dirtys,
  input  dcache_geom_pkg::tag_t      tags  [dcache_geom_pkg::NUM_WAYS],
  input  dcache_geom_pkg::line_t     lines [dcache_geom_pkg::NUM_WAYS],
  input  dcache_geom_pkg::word_sel_t word_sel,
  input  logic                       miss_start,
  output logic                       any_hit,
  output dcache_geom_pkg::word_t     read_word,
  output dcache_geom_pkg::way_vec_t  victim_onehot,
  output logic                       victim_dirty,
  output dcache_geom_pkg::tag_t      victim_tag,
  output dcache_geom_pkg::line_t     victim_line
);

  dcache_geom_pkg::way_idx_t hit_idx;     // lowest hitting way
  dcache_geom_pkg::way_idx_t inv_idx;     // lowest invalid way
  dcache_geom_pkg::way_idx_t rr_ptr;      // round robin once the set is full
  dcache_geom_pkg::way_idx_t victim_q;
  logic                      have_invalid;

  assign any_hit      = |hits;
  assign have_invalid = ~&valids;

  // priority encoders, scan downwards so the lowest way wins
  always_comb begin
    hit_idx = '0;
    inv_idx = '0;
    for (int w = dcache_geom_pkg::NUM_WAYS - 1; w >= 0; w--) begin
      if (hits[w])    hit_idx = dcache_geom_pkg::way_idx_t'(w);
      if (!valids[w]) inv_idx = dcache_geom_pkg::way_idx_t'(w);
    end
  end

  assign read_word = lines[hit_idx][word_sel*dcache_geom_pkg::WORD_W +: dcache_geom_pkg::WORD_W];

  // victim latch, stable for the whole miss
  always_ff @(posedge clk) begin
    if (rst) begin
      victim_q <= '0;
      rr_ptr   <= '0;
    end else if (miss_start) begin
      if (have_invalid) begin
        victim_q <= inv_idx;
      end else begin
        victim_q <= rr_ptr;
        rr_ptr   <= (rr_ptr == dcache_geom_pkg::way_idx_t'(dcache_geom_pkg::NUM_WAYS - 1)) ?
                    '0 : rr_ptr + 1'b1;
      end
    end
  end

  assign victim_onehot = dcache_geom_pkg::way_vec_t'(1) << victim_q;
  assign victim_dirty  = dirtys[victim_q];
  assign victim_tag    = tags[victim_q];
  assign victim_line   = lines[victim_q];

endmodule

`default_nettype wire

// ==== hdl/dcache_way.sv ====
`default_nettype none

module dcache_way (
  input  logic                       clk,
  input  logic                       rst,
  input  dcache_geom_pkg::index_t    index,
  input  dcache_geom_pkg::tag_t      tag,
  input  dcache_geom_pkg::word_sel_t word_sel,
  input  dcache_geom_pkg::word_t     store_wdata,
  input  dcache_geom_pkg::strb_t     store_wstrb,
  input  logic                       store_en,
  input  logic                       fill_en,
  input  dcache_geom_pkg::word_t     fill_data,
  input  logic                       victim_sel,    // this way is being refilled
  output logic                       hit,
  output logic                       valid,
  output logic                       dirty,
  output dcache_geom_pkg::tag_t      tag_out,
  output dcache_geom_pkg::line_t     line
);

  logic [dcache_geom_pkg::NUM_SETS-1:0] valid_q;
  logic [dcache_geom_pkg::NUM_SETS-1:0] dirty_q;
  dcache_geom_pkg::tag_t  tag_mem  [dcache_geom_pkg::NUM_SETS];
  dcache_geom_pkg::line_t line_mem [dcache_geom_pkg::NUM_SETS];

  dcache_geom_pkg::word_t cur_word;  // word addressed by the cpu
  dcache_geom_pkg::word_t merged;    // cur_word with the store applied

  logic do_fill;
  logic do_store;

  // combinational read of the selected set
  assign valid   = valid_q[index];
  assign dirty   = dirty_q[index];
  assign tag_out = tag_mem[index];
  assign line    = line_mem[index];
  assign hit     = valid && (tag_out == tag);

  assign do_fill  = fill_en && victim_sel;
  assign do_store = store_en && hit;

  // byte merge under strobes
  always_comb begin
    cur_word = line[word_sel*dcache_geom_pkg::WORD_W +: dcache_geom_pkg::WORD_W];
    for (int b = 0; b < dcache_geom_pkg::STRB_W; b++) begin
      merged[b*8 +: 8] = store_wstrb[b] ? store_wdata[b*8 +: 8] : cur_word[b*8 +: 8];
    end
  end

  // status bits
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
      dirty_q <= '0;
    end else if (do_fill) begin
      valid_q[index] <= 1'b1;
      dirty_q[index] <= 1'b0;   // fresh copy of memory
    end else if (do_store) begin
      dirty_q[index] <= 1'b1;
    end
  end

  // tag and data storage
  always_ff @(posedge clk) begin
    if (do_fill) begin
      // new beat enters at the top, after eight beats word 0 is at the bottom
      line_mem[index] <= {fill_data, line[dcache_geom_pkg::LINE_W-1:dcache_geom_pkg::WORD_W]};
      tag_mem[index]  <= tag;
    end else if (do_store) begin
      line_mem[index][word_sel*dcache_geom_pkg::WORD_W +: dcache_geom_pkg::WORD_W] <= merged;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/dcache_ctrl.sv ====
`default_nettype none

module dcache_ctrl (
  input  logic                       clk,
  input  logic                       rst,
  // cpu request / response
  input  logic                       req_valid,
  input  logic                       req_write,
  input  dcache_geom_pkg::addr_t     req_addr,
  input  dcache_geom_pkg::word_t     req_wdata,
  input  dcache_geom_pkg::strb_t     req_wstrb,
  output logic                       req_ready,
  output logic                       rsp_valid,
  output dcache_geom_pkg::word_t     rsp_data,
  input  logic                       rsp_ready,
  // memory read side
  output logic                       rd_req_valid,
  output dcache_geom_pkg::addr_t     rd_req_addr,
  input  logic                       rd_req_ready,
  input  logic                       rd_rsp_valid,
  input  dcache_geom_pkg::word_t     rd_rsp_data,
  input  logic                       rd_rsp_last,
  output logic                       rd_rsp_ready,
  // memory write side
  output logic                       wr_req_valid,
  output dcache_geom_pkg::addr_t     wr_req_addr,
  input  logic                       wr_req_ready,
  output logic                       wr_data_valid,
  output dcache_geom_pkg::word_t     wr_data,
  output logic                       wr_data_last,
  input  logic                       wr_data_ready,
  // common way controls
  output dcache_geom_pkg::index_t    index,
  output dcache_geom_pkg::tag_t      tag,
  output dcache_geom_pkg::word_sel_t word_sel,
  output dcache_geom_pkg::word_t     store_wdata,
  output dcache_geom_pkg::strb_t     store_wstrb,
  output logic                       store_en,
  output logic                       fill_en,
  output dcache_geom_pkg::word_t     fill_data,
  // way selector
  input  logic                       any_hit,
  input  dcache_geom_pkg::word_t     read_word,
  input  logic                       victim_dirty,
  input  dcache_geom_pkg::tag_t      victim_tag,
  input  dcache_geom_pkg::line_t     victim_line,
  output logic                       miss_start
);

  dcache_ctrl_pkg::ctrl_state_t state;
  dcache_ctrl_pkg::ctrl_state_t state_next;
  dcache_ctrl_pkg::beat_cnt_t   beat_cnt;     // write-back beats sent so far
  dcache_geom_pkg::line_t       wb_shift;     // victim line, word 0 goes out first

  logic wr_req_fire;
  logic wr_beat_fire;
  logic rd_last_fire;

  // cpu holds the request until req_ready, so decode straight from the port
  assign tag      = req_addr[dcache_geom_pkg::ADDR_W-1 -: dcache_geom_pkg::TAG_W];
  assign index    = req_addr[dcache_geom_pkg::OFFSET_W +: dcache_geom_pkg::INDEX_W];
  assign word_sel = req_addr[dcache_geom_pkg::BYTE_W +: dcache_geom_pkg::WSEL_W];

  assign wr_req_fire  = (state == dcache_ctrl_pkg::wb_req) && wr_req_ready;
  assign wr_beat_fire = (state == dcache_ctrl_pkg::wb_data) && wr_data_ready;
  assign rd_last_fire = (state == dcache_ctrl_pkg::fill_data) && rd_rsp_valid && rd_rsp_last;

  // next state
  always_comb begin
    state_next = state;
    case (state)
      dcache_ctrl_pkg::idle: begin
        if (req_valid) begin
          if (any_hit) begin
            state_next = req_write ? dcache_ctrl_pkg::write_hit : dcache_ctrl_pkg::read_hit;
          end else begin
            state_next = dcache_ctrl_pkg::evict_check;
          end
        end
      end
      dcache_ctrl_pkg::evict_check: begin
        // clean victims skip straight to the refill
        state_next = victim_dirty ? dcache_ctrl_pkg::wb_req : dcache_ctrl_pkg::fill_req;
      end
      dcache_ctrl_pkg::wb_req: begin
        if (wr_req_ready) state_next = dcache_ctrl_pkg::wb_data;
      end
      dcache_ctrl_pkg::wb_data: begin
        if (wr_beat_fire && wr_data_last) state_next = dcache_ctrl_pkg::fill_req;
      end
      dcache_ctrl_pkg::fill_req: begin
        if (rd_req_ready) state_next = dcache_ctrl_pkg::fill_data;
      end
      dcache_ctrl_pkg::fill_data: begin
        // line now present, finish as a hit
        if (rd_last_fire) begin
          state_next = req_write ? dcache_ctrl_pkg::write_hit : dcache_ctrl_pkg::read_hit;
        end
      end
      dcache_ctrl_pkg::write_hit: state_next = dcache_ctrl_pkg::idle;
      dcache_ctrl_pkg::read_hit:  state_next = dcache_ctrl_pkg::respond;
      dcache_ctrl_pkg::respond: begin
        if (rsp_ready) state_next = dcache_ctrl_pkg::idle;
      end
      default: state_next = dcache_ctrl_pkg::idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= dcache_ctrl_pkg::idle;
    end else begin
      state <= state_next;
    end
  end

  // write-back beat counter, drives last
  always_ff @(posedge clk) begin
    if (rst) begin
      beat_cnt <= '0;
    end else if (wr_req_fire) begin
      beat_cnt <= '0;
    end else if (wr_beat_fire) begin
      beat_cnt <= beat_cnt + 4'd1;
    end
  end

  // victim shifter, loaded on address accept
  always_ff @(posedge clk) begin
    if (wr_req_fire) begin
      wb_shift <= victim_line;
    end else if (wr_beat_fire) begin
      wb_shift <= {dcache_geom_pkg::word_t'(0),
                   wb_shift[dcache_geom_pkg::LINE_W-1:dcache_geom_pkg::WORD_W]};
    end
  end

  // read data captured in the hit cycle, held through respond
  always_ff @(posedge clk) begin
    if (state == dcache_ctrl_pkg::read_hit) rsp_data <= read_word;
  end

  // cpu side
  assign req_ready = (state == dcache_ctrl_pkg::write_hit) ||
                     (state == dcache_ctrl_pkg::read_hit);
  assign rsp_valid = (state == dcache_ctrl_pkg::respond);

  // memory read side, line aligned
  assign rd_req_valid = (state == dcache_ctrl_pkg::fill_req);
  assign rd_req_addr  = {tag, index, {dcache_geom_pkg::OFFSET_W{1'b0}}};
  assign rd_rsp_ready = (state == dcache_ctrl_pkg::fill_data);

  // memory write side
  assign wr_req_valid  = (state == dcache_ctrl_pkg::wb_req);
  assign wr_req_addr   = {victim_tag, index, {dcache_geom_pkg::OFFSET_W{1'b0}}};
  assign wr_data_valid = (state == dcache_ctrl_pkg::wb_data);
  assign wr_data       = wb_shift[dcache_geom_pkg::WORD_W-1:0];
  assign wr_data_last  = wr_data_valid && (beat_cnt == dcache_ctrl_pkg::LAST_BEAT);

  // way controls
  assign store_wdata = req_wdata;
  assign store_wstrb = req_wstrb;
  assign store_en    = (state == dcache_ctrl_pkg::write_hit);
  assign fill_en     = (state == dcache_ctrl_pkg::fill_data) && rd_rsp_valid;
  assign fill_data   = rd_rsp_data;
  assign miss_start  = (state == dcache_ctrl_pkg::idle) && req_valid && !any_hit; // latch victim

endmodule

`default_nettype wire

// ==== hdl/dcache_ctrl_pkg.sv ====
`default_nettype none

package dcache_ctrl_pkg;

  // controller states, miss path runs evict_check .. fill_data
  typedef enum logic [3:0] {
    idle,         // wait for a cpu request
    evict_check,  // victim latched, decide on write-back
    wb_req,       // write-back address phase
    wb_data,      // write-back beats
    fill_req,     // refill address phase
    fill_data,    // refill beats
    write_hit,    // merge store, accept request
    read_hit,     // capture word, accept request
    respond       // hold read data until cpu takes it
  } ctrl_state_t;

  typedef logic [3:0] beat_cnt_t;

  localparam beat_cnt_t BURST_BEATS = 4'd8;              // beats per line burst
  localparam beat_cnt_t LAST_BEAT   = BURST_BEATS - 4'd1;

endpackage

`default_nettype wire

// ==== hdl/dcache_geom_pkg.sv ====
`default_nettype none

package dcache_geom_pkg;

  // cache shape
  localparam int NUM_WAYS       = 6;
  localparam int NUM_SETS       = 8;
  localparam int WORDS_PER_LINE = 8;

  // datapath widths
  localparam int ADDR_W = 32;
  localparam int WORD_W = 32;
  localparam int STRB_W = WORD_W / 8;           // one strobe per byte
  localparam int LINE_W = WORD_W * WORDS_PER_LINE;

  // address split: | tag | index | word | byte |
  localparam int BYTE_W   = $clog2(STRB_W);     // byte within a word
  localparam int WSEL_W   = $clog2(WORDS_PER_LINE);
  localparam int OFFSET_W = WSEL_W + BYTE_W;    // byte within a line
  localparam int INDEX_W  = $clog2(NUM_SETS);
  localparam int TAG_W    = ADDR_W - INDEX_W - OFFSET_W;
  localparam int WAY_W    = $clog2(NUM_WAYS);

  typedef logic [ADDR_W-1:0]   addr_t;          // byte address
  typedef logic [WORD_W-1:0]   word_t;          // cpu / memory beat
  typedef logic [STRB_W-1:0]   strb_t;          // byte enables
  typedef logic [TAG_W-1:0]    tag_t;           // upper 24 address bits
  typedef logic [INDEX_W-1:0]  index_t;         // set number
  typedef logic [WSEL_W-1:0]   word_sel_t;      // word inside a line
  typedef logic [LINE_W-1:0]   line_t;          // word 0 sits in the low bits
  typedef logic [NUM_WAYS-1:0] way_vec_t;       // one bit per way
  typedef logic [WAY_W-1:0]    way_idx_t;       // way number

endpackage

`default_nettype wire
